// File: Bender.yml
package:
  name: packet_read

sources:
  - hdl/packet_pkg.sv
  - hdl/fifo_sync.sv
  - hdl/packet_mem.sv
  - hdl/packet_read.sv
  - hdl/packet_read_top.sv
  - target: simulation
    files:
      - verification/packet_read_asserts.sv
      - verification/packet_read_tb.sv

// File: hdl/fifo_sync.sv
// --------------------
// Synchronous FIFO, first-word fall-through
// Payload type set by parameter
// Fill count and overflow flag
// --------------------

module fifo_sync #(
    parameter type DATA_T = logic [7:0],
    parameter int  DEPTH  = 8
) (
    input  logic                       clk,
    input  logic                       srst,

    input  logic                       wr,
    input  DATA_T                      wr_data,
    output logic [$clog2(DEPTH+1)-1:0] wr_count,
    output logic                       oflow,

    input  logic                       rd,
    output logic                       rd_ack,
    output DATA_T                      rd_data
);
    localparam int PTR_WID = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_WID = $clog2(DEPTH+1);

    DATA_T              mem [DEPTH];
    logic [PTR_WID-1:0] wr_ptr;
    logic [PTR_WID-1:0] rd_ptr;
    logic [CNT_WID-1:0] count;
    logic               full;
    logic               empty;
    logic               wr_ok;
    logic               rd_ok;

    // Circular pointer advance
    function automatic logic [PTR_WID-1:0] ptr_inc(input logic [PTR_WID-1:0] ptr);
        return (ptr == PTR_WID'(DEPTH-1)) ? '0 : ptr + 1'b1;
    endfunction

    assign empty = (count == '0);
    assign full  = (count == CNT_WID'(DEPTH));
    assign wr_ok = wr && !full;
    assign rd_ok = rd && !empty;

    // --------------------
    // Storage
    // --------------------
    always_ff @(posedge clk) begin
        if (wr_ok) mem[wr_ptr] <= wr_data;
    end

    // Pointers and occupancy
    always_ff @(posedge clk) begin
        if (srst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            oflow  <= 1'b0;
        end else begin
            if (wr_ok) wr_ptr <= ptr_inc(wr_ptr);
            if (rd_ok) rd_ptr <= ptr_inc(rd_ptr);
            case ({wr_ok, rd_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // Write dropped when full
            oflow <= wr && full;
        end
    end

    // Head entry shown whenever not empty
    assign rd_ack   = !empty;
    assign rd_data  = mem[rd_ptr];
    assign wr_count = count;

endmodule : fifo_sync

// File: hdl/packet_mem.sv
// --------------------
// Packet word memory
// One write port for loading images
// One read port, fixed read latency
// --------------------

module packet_mem #(
    parameter int RD_LATENCY = 4
) (
    input  logic              clk,
    input  logic              srst,

    input  logic              wr_en,
    input  packet_pkg::addr_t wr_addr,
    input  packet_pkg::data_t wr_data,

    input  logic              rd_req,
    input  packet_pkg::addr_t rd_addr,
    output logic              rd_ack,
    output packet_pkg::data_t rd_data
);
    import packet_pkg::*;

    localparam int MEM_DEPTH = 2**ADDR_WID;

    data_t                 mem [MEM_DEPTH];
    logic [RD_LATENCY-1:0] valid_pipe;
    data_t                 data_pipe [RD_LATENCY];

    // --------------------
    // Array
    // --------------------
    always_ff @(posedge clk) begin
        if (wr_en) mem[wr_addr] <= wr_data;
    end

    // Read pipeline, valid side
    always_ff @(posedge clk) begin
        if (srst) begin
            valid_pipe <= '0;
        end else begin
            valid_pipe[0] <= rd_req;
            for (int i = 1; i < RD_LATENCY; i++) begin
                valid_pipe[i] <= valid_pipe[i-1];
            end
        end
    end

    // Read pipeline, data side
    always_ff @(posedge clk) begin
        data_pipe[0] <= mem[rd_addr];
        for (int i = 1; i < RD_LATENCY; i++) begin
            data_pipe[i] <= data_pipe[i-1];
        end
    end

    assign rd_ack  = valid_pipe[RD_LATENCY-1];
    assign rd_data = data_pipe[RD_LATENCY-1];

endmodule : packet_mem

// File: hdl/packet_pkg.sv
// --------------------
// Shared stream parameters and types
// for the packet reader subsystem
// --------------------

package packet_pkg;

    // Stream and memory word geometry
    localparam int DATA_BYTE_WID = 8;
    localparam int MTY_WID       = $clog2(DATA_BYTE_WID);

    localparam int ADDR_WID = 10;
    localparam int SIZE_WID = 12;
    localparam int META_WID = 8;

    // --------------------
    // Types
    // --------------------

    // Byte 0 is the MSB and the first byte on the wire
    typedef logic [0:DATA_BYTE_WID-1][7:0] data_t;

    typedef logic [ADDR_WID-1:0] addr_t;
    typedef logic [SIZE_WID-1:0] size_t;
    typedef logic [META_WID-1:0] meta_t;

    // Empty trailing bytes in the last word
    typedef logic [MTY_WID-1:0] mty_t;

endpackage : packet_pkg

// File: hdl/packet_read.sv
// --------------------
// Descriptor-driven packet read engine
// Read FSM, read pointer, word counter
// Per-word context generation
// Prefetch buffers for data and context
// Completion event
// --------------------

module packet_read #(
    parameter int MAX_RD_LATENCY = 8
) (
    input  logic              clk,
    input  logic              srst,

    // Descriptor
    input  logic              desc_valid,
    input  packet_pkg::addr_t desc_addr,
    input  packet_pkg::size_t desc_size,
    input  packet_pkg::meta_t desc_meta,
    output logic              desc_rdy,

    // Packet stream
    output logic              pkt_valid,
    output packet_pkg::data_t pkt_data,
    output logic              pkt_eop,
    output packet_pkg::mty_t  pkt_mty,
    output packet_pkg::meta_t pkt_meta,
    input  logic              pkt_rdy,

    // Completion event
    output logic              evt,
    output packet_pkg::size_t evt_size,

    // Memory read
    output logic              mem_req,
    output packet_pkg::addr_t mem_addr,
    input  logic              mem_ack,
    input  packet_pkg::data_t mem_data
);
    import packet_pkg::*;

    // --------------------
    // Parameters and types
    // --------------------
    localparam int PREFETCH_DEPTH   = (MAX_RD_LATENCY * 2 > 8) ? MAX_RD_LATENCY * 2 : 8;
    localparam int PREFETCH_CNT_WID = $clog2(PREFETCH_DEPTH+1);
    localparam int WORD_CNT_WID     = SIZE_WID - MTY_WID;

    typedef enum logic [1:0] {
        RESET = 2'd0,
        READY = 2'd1,
        BUSY  = 2'd2
    } state_t;

    typedef struct packed {
        logic  eop;
        mty_t  mty;
        meta_t meta;
        size_t size;
    } ctxt_t;

    state_t                      state;
    state_t                      nxt_state;
    logic                        desc_accept;

    addr_t                       rd_ptr;
    logic [WORD_CNT_WID-1:0]     rd_word;
    logic [WORD_CNT_WID-1:0]     last_word;
    mty_t                        last_mty;
    meta_t                       cur_meta;
    size_t                       cur_size;
    size_t                       size_m1;

    logic                        prefetch_rdy;
    logic                        prefetch_eop;
    logic [PREFETCH_CNT_WID-1:0] prefetch_cnt;

    ctxt_t                       ctxt_in;
    ctxt_t                       ctxt_out;

    // --------------------
    // Read FSM
    // --------------------
    always_ff @(posedge clk) begin
        if (srst) state <= RESET;
        else      state <= nxt_state;
    end

    always_comb begin
        nxt_state = state;
        case (state)
            RESET: nxt_state = READY;
            READY: if (desc_valid) nxt_state = BUSY;
            // Leave once the last word's read is issued
            BUSY:  if (mem_req && prefetch_eop) nxt_state = READY;
            default: nxt_state = RESET;
        endcase
    end

    assign desc_rdy    = (state == READY);
    assign desc_accept = desc_valid && desc_rdy;

    // Issue a read while prefetch is under half full
    assign prefetch_rdy = (prefetch_cnt < PREFETCH_CNT_WID'(PREFETCH_DEPTH / 2));
    assign mem_req      = (state == BUSY) && prefetch_rdy;
    assign mem_addr     = rd_ptr;

    // Read pointer and word counter
    always_ff @(posedge clk) begin
        if (desc_accept) begin
            rd_ptr  <= desc_addr;
            rd_word <= '0;
        end else if (mem_req) begin
            rd_ptr  <= rd_ptr + 1'b1;
            rd_word <= rd_word + 1'b1;
        end
    end

    // --------------------
    // Descriptor latch
    // --------------------
    assign size_m1 = desc_size - 1'b1;

    always_ff @(posedge clk) begin
        if (desc_accept) begin
            last_word <= size_m1[SIZE_WID-1:MTY_WID];
            // Cast keeps the result modulo the word size
            last_mty  <= mty_t'(DATA_BYTE_WID - desc_size[MTY_WID-1:0]);
            cur_meta  <= desc_meta;
            cur_size  <= desc_size;
        end
    end

    assign prefetch_eop = (rd_word == last_word);

    // Context for the word being requested
    assign ctxt_in.eop  = prefetch_eop;
    assign ctxt_in.mty  = prefetch_eop ? last_mty : '0;
    assign ctxt_in.meta = cur_meta;
    assign ctxt_in.size = cur_size;

    // --------------------
    // Prefetch buffers
    // --------------------
    fifo_sync #(
        .DATA_T   ( data_t ),
        .DEPTH    ( PREFETCH_DEPTH )
    ) prefetch_data_i (
        .clk      ( clk ),
        .srst     ( srst ),
        .wr       ( mem_ack ),
        .wr_data  ( mem_data ),
        .wr_count ( prefetch_cnt ),
        .oflow    ( ),
        .rd       ( pkt_rdy ),
        .rd_ack   ( pkt_valid ),
        .rd_data  ( pkt_data )
    );

    // Context queued at request time, popped with each word
    fifo_sync #(
        .DATA_T   ( ctxt_t ),
        .DEPTH    ( PREFETCH_DEPTH )
    ) prefetch_ctxt_i (
        .clk      ( clk ),
        .srst     ( srst ),
        .wr       ( mem_req ),
        .wr_data  ( ctxt_in ),
        .wr_count ( ),
        .oflow    ( ),
        .rd       ( pkt_valid && pkt_rdy ),
        .rd_ack   ( ),
        .rd_data  ( ctxt_out )
    );

    assign pkt_eop  = ctxt_out.eop;
    assign pkt_mty  = ctxt_out.mty;
    assign pkt_meta = ctxt_out.meta;

    // One event per last-word transfer
    assign evt      = pkt_valid && pkt_rdy && ctxt_out.eop;
    assign evt_size = ctxt_out.size;

endmodule : packet_read

// File: hdl/packet_read_top.sv
// --------------------
// Packet reader top level
// Reader plus word memory with load port
// --------------------

module packet_read_top #(
    parameter int RD_LATENCY = 4
) (
    input  logic              clk,
    input  logic              srst,

    input  logic              desc_valid,
    input  packet_pkg::addr_t desc_addr,
    input  packet_pkg::size_t desc_size,
    input  packet_pkg::meta_t desc_meta,
    output logic              desc_rdy,

    output logic              pkt_valid,
    output packet_pkg::data_t pkt_data,
    output logic              pkt_eop,
    output packet_pkg::mty_t  pkt_mty,
    output packet_pkg::meta_t pkt_meta,
    input  logic              pkt_rdy,

    output logic              evt,
    output packet_pkg::size_t evt_size,

    input  logic              load_en,
    input  packet_pkg::addr_t load_addr,
    input  packet_pkg::data_t load_data
);
    import packet_pkg::*;

    // Reader to memory
    logic  mem_req;
    addr_t mem_addr;
    logic  mem_ack;
    data_t mem_data;

    packet_read #(
        .MAX_RD_LATENCY ( RD_LATENCY )
    ) packet_read_i (
        .clk        ( clk ),
        .srst       ( srst ),
        .desc_valid ( desc_valid ),
        .desc_addr  ( desc_addr ),
        .desc_size  ( desc_size ),
        .desc_meta  ( desc_meta ),
        .desc_rdy   ( desc_rdy ),
        .pkt_valid  ( pkt_valid ),
        .pkt_data   ( pkt_data ),
        .pkt_eop    ( pkt_eop ),
        .pkt_mty    ( pkt_mty ),
        .pkt_meta   ( pkt_meta ),
        .pkt_rdy    ( pkt_rdy ),
        .evt        ( evt ),
        .evt_size   ( evt_size ),
        .mem_req    ( mem_req ),
        .mem_addr   ( mem_addr ),
        .mem_ack    ( mem_ack ),
        .mem_data   ( mem_data )
    );

    packet_mem #(
        .RD_LATENCY ( RD_LATENCY )
    ) packet_mem_i (
        .clk     ( clk ),
        .srst    ( srst ),
        .wr_en   ( load_en ),
        .wr_addr ( load_addr ),
        .wr_data ( load_data ),
        .rd_req  ( mem_req ),
        .rd_addr ( mem_addr ),
        .rd_ack  ( mem_ack ),
        .rd_data ( mem_data )
    );

endmodule : packet_read_top

// File: packet_read.f
hdl/packet_pkg.sv
hdl/fifo_sync.sv
hdl/packet_mem.sv
hdl/packet_read.sv
hdl/packet_read_top.sv
verification/packet_read_asserts.sv
verification/packet_read_tb.sv

// File: verification/packet_read_asserts.sv
// --------------------
// Concurrent checks for the packet reader
// Stall stability, descriptor handshake,
// event qualification, prefetch overflow
// --------------------

module packet_read_asserts (
    input logic              clk,
    input logic              srst,
    input logic              desc_valid,
    input logic              desc_rdy,
    input logic              pkt_valid,
    input packet_pkg::data_t pkt_data,
    input logic              pkt_eop,
    input packet_pkg::mty_t  pkt_mty,
    input packet_pkg::meta_t pkt_meta,
    input logic              pkt_rdy,
    input logic              evt,
    input logic              prefetch_oflow
);

    int fail_count = 0;

    // Packet outputs frozen while the sink stalls
    a_stall_hold: assert property (@(posedge clk) disable iff (srst)
        pkt_valid && !pkt_rdy |=> pkt_valid && $stable(pkt_data) && $stable(pkt_eop)
            && $stable(pkt_mty) && $stable(pkt_meta))
        else begin
            fail_count++;
            $error("packet outputs changed while stalled");
        end

    a_desc_busy: assert property (@(posedge clk) disable iff (srst)
        desc_valid && desc_rdy |=> !desc_rdy)
        else begin
            fail_count++;
            $error("desc_rdy high in the cycle after an acceptance");
        end

    // Event only on a last-word transfer
    a_evt_eop: assert property (@(posedge clk) disable iff (srst)
        evt |-> pkt_valid && pkt_rdy && pkt_eop)
        else begin
            fail_count++;
            $error("evt without a last-word transfer");
        end

    a_no_oflow: assert property (@(posedge clk) disable iff (srst)
        !prefetch_oflow)
        else begin
            fail_count++;
            $error("prefetch data FIFO overflow");
        end

endmodule : packet_read_asserts

bind packet_read_top packet_read_asserts asserts_i (
    .clk            ( clk ),
    .srst           ( srst ),
    .desc_valid     ( desc_valid ),
    .desc_rdy       ( desc_rdy ),
    .pkt_valid      ( pkt_valid ),
    .pkt_data       ( pkt_data ),
    .pkt_eop        ( pkt_eop ),
    .pkt_mty        ( pkt_mty ),
    .pkt_meta       ( pkt_meta ),
    .pkt_rdy        ( pkt_rdy ),
    .evt            ( evt ),
    .prefetch_oflow ( packet_read_i.prefetch_data_i.oflow )
);

// File: verification/packet_read_tb.sv
// --------------------
// Packet reader testbench
// Clock, reset, memory image load, descriptor and back-pressure stimulus
// Reference model, monitor with compare tasks, watchdog, summary
// --------------------

module packet_read_tb;
    import packet_pkg::*;

    localparam int RD_LATENCY = 4;
    localparam int N_EDGE     = 5;
    localparam int N_RAND     = 50;
    localparam int N_DESC     = N_EDGE + 2 * N_RAND;
    localparam int MEM_WORDS  = 2**ADDR_WID;

    typedef struct packed {
        data_t data;
        logic  eop;
        mty_t  mty;
        meta_t meta;
    } word_exp_t;

    logic  clk        = 1'b0;
    logic  srst       = 1'b1;
    logic  desc_valid = 1'b0;
    addr_t desc_addr  = '0;
    size_t desc_size  = '0;
    meta_t desc_meta  = '0;
    logic  desc_rdy;
    logic  pkt_valid;
    data_t pkt_data;
    logic  pkt_eop;
    mty_t  pkt_mty;
    meta_t pkt_meta;
    logic  pkt_rdy    = 1'b1;
    logic  evt;
    size_t evt_size;
    logic  load_en    = 1'b0;
    addr_t load_addr  = '0;
    data_t load_data  = '0;

    integer seed    = 32'hd6ce4cf5;
    logic   bp_en   = 1'b0;
    logic   gen_done = 1'b0;

    data_t shadow [MEM_WORDS];
    addr_t d_addr [N_DESC];
    size_t d_size [N_DESC];
    meta_t d_meta [N_DESC];
    int    accepted [$];

    int errors      = 0;
    int n_checks    = 0;
    int n_tests     = 0;
    int err_mark    = 0;
    int words_seen  = 0;
    int n_evt       = 0;
    int pkts_done   = 0;
    int n_accepted  = 0;
    int word_idx    = 0;
    int total_bytes = 0;

    packet_read_top #(
        .RD_LATENCY ( RD_LATENCY )
    ) dut_i (
        .clk        ( clk ),
        .srst       ( srst ),
        .desc_valid ( desc_valid ),
        .desc_addr  ( desc_addr ),
        .desc_size  ( desc_size ),
        .desc_meta  ( desc_meta ),
        .desc_rdy   ( desc_rdy ),
        .pkt_valid  ( pkt_valid ),
        .pkt_data   ( pkt_data ),
        .pkt_eop    ( pkt_eop ),
        .pkt_mty    ( pkt_mty ),
        .pkt_meta   ( pkt_meta ),
        .pkt_rdy    ( pkt_rdy ),
        .evt        ( evt ),
        .evt_size   ( evt_size ),
        .load_en    ( load_en ),
        .load_addr  ( load_addr ),
        .load_data  ( load_data )
    );

    always #50 clk = ~clk;

    // --------------------
    // Reference model
    // --------------------

    // Expected word idx of descriptor d
    // Addresses wrap around the memory
    function automatic word_exp_t expect_word(input int d, input int idx);
        word_exp_t w;
        int        n_words;
        n_words = (int'(d_size[d]) + DATA_BYTE_WID - 1) / DATA_BYTE_WID;
        w.data  = shadow[addr_t'(int'(d_addr[d]) + idx)];
        w.eop   = (idx == n_words - 1);
        w.mty   = w.eop ? mty_t'(n_words * DATA_BYTE_WID - int'(d_size[d])) : '0;
        w.meta  = d_meta[d];
        return w;
    endfunction

    // --------------------
    // Compare tasks
    // --------------------
    task automatic report_error(input string msg);
        errors++;
        $display("ERROR: %s", msg);
    endtask

    task automatic check_data(input string name, input data_t got, input data_t exp);
        n_checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_mty(input string name, input mty_t got, input mty_t exp);
        n_checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_meta(input string name, input meta_t got, input meta_t exp);
        n_checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_size(input string name, input size_t got, input size_t exp);
        n_checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        n_checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %s: got %h expected %h", name, got, exp);
        end
    endtask

    // --------------------
    // Stimulus helpers
    // --------------------

    // Returns on the edge where the descriptor transfers
    task automatic send_desc(input int d);
        desc_valid <= 1'b1;
        desc_addr  <= d_addr[d];
        desc_size  <= d_size[d];
        desc_meta  <= d_meta[d];
        do @(posedge clk); while (!desc_rdy);
    endtask

    task automatic wait_packets(input int target);
        while (pkts_done < target) @(negedge clk);
        @(posedge clk);
    endtask

    task automatic end_test(input string name);
        n_tests++;
        $display("Test %0d %s: %0d errors", n_tests, name, errors - err_mark);
        err_mark = errors;
    endtask

    // Sink ready goes random when back-pressure is on
    always @(posedge clk) begin
        integer rnd;
        if (bp_en) begin
            rnd = $random(seed);
            pkt_rdy <= rnd[0];
        end else begin
            pkt_rdy <= 1'b1;
        end
    end

    // --------------------
    // Monitor
    // --------------------
    always @(posedge clk) begin
        word_exp_t exp;
        if (!srst) begin
            if (desc_valid && desc_rdy) begin
                accepted.push_back(n_accepted);
                n_accepted++;
            end
            if (evt && !(pkt_valid && pkt_rdy))
                report_error("event raised without a word transfer");
            if (pkt_valid && pkt_rdy) begin
                if (accepted.size() == 0) begin
                    report_error("word transferred with no descriptor outstanding");
                end else begin
                    exp = expect_word(accepted[0], word_idx);
                    check_data("pkt_data", pkt_data, exp.data);
                    check_flag("pkt_eop", pkt_eop, exp.eop);
                    check_mty("pkt_mty", pkt_mty, exp.mty);
                    check_meta("pkt_meta", pkt_meta, exp.meta);
                    check_flag("evt", evt, exp.eop);
                    if (evt) begin
                        check_size("evt_size", evt_size, d_size[accepted[0]]);
                        n_evt++;
                    end
                    words_seen++;
                    if (exp.eop) begin
                        void'(accepted.pop_front());
                        word_idx = 0;
                        pkts_done++;
                    end else begin
                        word_idx++;
                    end
                end
            end
        end
    end

    // Watchdog scaled by the total traffic
    initial begin
        wait (gen_done);
        repeat (total_bytes * 2 + 2000) @(posedge clk);
        $display("Timeout: packets did not complete within the expected time");
        $display("*** TEST FAILED ***");
        $finish;
    end

    // --------------------
    // Main sequence
    // --------------------
    initial begin
        logic rose;
        int   edge_sizes [N_EDGE];

        edge_sizes = '{1, 8, 9, 64, 4095};
        for (int a = 0; a < MEM_WORDS; a++) begin
            shadow[a] = {$random(seed), $random(seed)};
        end
        for (int d = 0; d < N_DESC; d++) begin
            d_addr[d] = addr_t'($random(seed));
            d_meta[d] = meta_t'($random(seed));
            if (d < N_EDGE)
                d_size[d] = size_t'(edge_sizes[d]);
            else
                d_size[d] = size_t'(1 + ($unsigned($random(seed)) % 256));
            total_bytes += int'(d_size[d]);
        end
        gen_done = 1'b1;

        // Reset with outputs checked mid-cycle
        for (int i = 0; i < 4; i++) begin
            @(posedge clk);
            if (i == 3) srst <= 1'b0;
            @(negedge clk);
            if (desc_rdy !== 1'b0 || pkt_valid !== 1'b0 || evt !== 1'b0)
                report_error("desc_rdy, pkt_valid or evt not low during reset");
        end
        rose = 1'b0;
        repeat (2) begin
            @(negedge clk);
            if (desc_rdy === 1'b1) rose = 1'b1;
        end
        if (!rose) report_error("desc_rdy did not rise within two cycles after reset");
        end_test("reset outputs");

        // Memory image
        for (int a = 0; a < MEM_WORDS; a++) begin
            @(posedge clk);
            load_en   <= 1'b1;
            load_addr <= addr_t'(a);
            load_data <= shadow[a];
        end
        @(posedge clk);
        load_en <= 1'b0;

        for (int d = 0; d < N_EDGE; d++) begin
            send_desc(d);
            desc_valid <= 1'b0;
            wait_packets(d + 1);
        end
        end_test("edge sizes");

        for (int d = N_EDGE; d < N_EDGE + N_RAND; d++) begin
            send_desc(d);
        end
        desc_valid <= 1'b0;
        wait_packets(N_EDGE + N_RAND);
        end_test("back-to-back");

        bp_en <= 1'b1;
        for (int d = N_EDGE + N_RAND; d < N_DESC; d++) begin
            send_desc(d);
        end
        desc_valid <= 1'b0;
        wait_packets(N_DESC);
        bp_en <= 1'b0;
        end_test("back-pressure");

        if (n_evt != N_DESC) report_error("event count differs from packet count");
        @(negedge clk);
        if (pkt_valid !== 1'b0 || desc_rdy !== 1'b1)
            report_error("reader not idle after the last packet");
        if (dut_i.asserts_i.fail_count != 0)
            report_error("bound assertions failed during the run");
        end_test("completion events");

        $display("Summary: %0d tests, %0d packets, %0d words, %0d checks, %0d errors",
                 n_tests, pkts_done, words_seen, n_checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule : packet_read_tb
